/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_st_sdram_mux -f src.f -o sim_tb

status=0
obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "sim failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished cleanly"

/* src.f */
src/st_cfg_pkg.sv
src/st_bus_pkg.sv
src/mem_map_decode.sv
src/viking_detect.sv
src/rom_upload.sv
src/sdram_req_mux.sv
src/st_sdram_mux.sv
test/st_sdram_mux_properties.sv
test/tb_st_sdram_mux.sv

/* src/mem_map_decode.sv */
`default_nettype none

module mem_map_decode (
	input  st_cfg_pkg::st_cfg_t    cfg_i,
	input  st_bus_pkg::bus_slot_e  bus_cycle_i,
	input  logic                   turbo_i,
	input  st_bus_pkg::word_addr_t ram_addr_i,
	input  st_bus_pkg::word_addr_t cpu_addr_i,
	output st_bus_pkg::slot_t      slot_o,
	output logic                   ram_en_o,
	output logic                   viking_enable_o,
	output logic                   cpu_in_window_o
);

	logic size_ok;

	// window position depends on steroids mode
	function automatic logic in_window(st_bus_pkg::word_addr_t a, logic steroids);
		logic hit;
		if (steroids) begin
			hit = (a[23:19] == st_cfg_pkg::VIKING_HI_TAG);
		end else begin
			hit = (a[23:18] == st_cfg_pkg::VIKING_LO_TAG);
		end
		return hit;
	endfunction

	// turbo moves the cpu slot forward by one
	assign slot_o.cpu_precycle    = (bus_cycle_i == st_bus_pkg::slot0);
	assign slot_o.cpu_cycle       = (bus_cycle_i == st_bus_pkg::slot1) ||
	                                (bus_cycle_i == st_bus_pkg::slot2 && turbo_i);
	assign slot_o.viking_cycle    = (bus_cycle_i == st_bus_pkg::slot2 && !turbo_i) ||
	                                (bus_cycle_i == st_bus_pkg::slot3 && turbo_i);
	assign slot_o.viking_precycle = (bus_cycle_i == st_bus_pkg::slot3 && !turbo_i) ||
	                                (bus_cycle_i == st_bus_pkg::slot1 && turbo_i);

	// card needs 8M or less, steroids always has it
	assign viking_enable_o = (cfg_i.viking_en && (cfg_i.mem_size inside {
		st_cfg_pkg::mem_512k, st_cfg_pkg::mem_1m, st_cfg_pkg::mem_2m,
		st_cfg_pkg::mem_4m, st_cfg_pkg::mem_8m})) || cfg_i.steroids;

	always_comb begin
		case (cfg_i.mem_size)
			st_cfg_pkg::mem_512k: size_ok = (ram_addr_i[23:19] == 5'b00000);
			st_cfg_pkg::mem_1m:   size_ok = (ram_addr_i[23:20] == 4'b0000);
			st_cfg_pkg::mem_2m:   size_ok = (ram_addr_i[23:21] == 3'b000);
			st_cfg_pkg::mem_4m:   size_ok = (ram_addr_i[23:22] == 2'b00);
			st_cfg_pkg::mem_8m:   size_ok = !ram_addr_i[23];
			// everything below e00000
			st_cfg_pkg::mem_14m:  size_ok = (ram_addr_i[23:21] != 3'b111);
			default:              size_ok = 1'b0;
		endcase
	end

	assign ram_en_o = size_ok ||
	                  (viking_enable_o && in_window(ram_addr_i, cfg_i.steroids));

	assign cpu_in_window_o = viking_enable_o && in_window(cpu_addr_i, cfg_i.steroids);

endmodule

`default_nettype wire

/* src/rom_upload.sv */
`default_nettype none

module rom_upload (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  st_bus_pkg::slot_t      slot_i,
	input  logic                   mhz8_en1_i,
	input  logic                   dl_strobe_i,
	input  logic                   dl_active_i,
	input  st_bus_pkg::word_addr_t dl_addr_i,
	input  st_bus_pkg::word_addr_t cpu_addr_i,
	input  logic                   rom2_n_i,
	output logic                   dl_wr_o,
	output logic                   tos192k_o,
	output st_bus_pkg::word_addr_t rom_addr_o
);

	// last sampled level of the toggle strobe
	logic strobe_d;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_d <= 1'b0;
			dl_wr_o  <= 1'b0;
		end else begin
			dl_wr_o <= 1'b0;
			// only sample once per bus cycle
			if (slot_i.cpu_precycle && mhz8_en1_i) begin
				strobe_d <= dl_strobe_i;
				if (dl_strobe_i != strobe_d) begin
					dl_wr_o <= 1'b1;
				end
			end
		end
	end

	// 192k TOS loads at fc0000, 256k TOS at e00000
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k_o <= 1'b0;
		end else if (dl_active_i) begin
			if (dl_addr_i[23:18] == 6'b111111) begin
				tos192k_o <= 1'b1;
			end else if (dl_addr_i[23:20] == 4'he) begin
				tos192k_o <= 1'b0;
			end
		end
	end

	// system rom image sits where it was uploaded
	always_comb begin
		if (!rom2_n_i && tos192k_o) begin
			rom_addr_o = {4'hf, 2'b11, cpu_addr_i[17:1]};
		end else if (!rom2_n_i) begin
			rom_addr_o = {4'he, 2'b00, cpu_addr_i[17:1]};
		end else begin
			rom_addr_o = cpu_addr_i;
		end
	end

endmodule

`default_nettype wire

/* src/sdram_req_mux.sv */
`default_nettype none

module sdram_req_mux (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  st_bus_pkg::slot_t      slot_i,
	input  logic                   ram_en_i,
	input  logic                   viking_active_i,
	input  logic                   viking_read_i,
	input  st_bus_pkg::word_addr_t viking_addr_i,
	input  logic                   dl_active_i,
	input  logic                   dl_wr_i,
	input  st_bus_pkg::word_addr_t dl_addr_i,
	input  st_bus_pkg::bus_word_t  dl_data_i,
	input  logic                   ram_ras_n_i,
	input  logic                   ram_ref_i,
	input  logic                   ram_we_n_i,
	input  logic                   ram_uds_i,
	input  logic                   ram_lds_i,
	input  st_bus_pkg::word_addr_t ram_addr_i,
	input  st_bus_pkg::bus_word_t  ram_din_i,
	output st_bus_pkg::sdram_req_t sdram_o
);

	logic ras_n_d;
	logic ram_req;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_d <= 1'b1;
		end else begin
			ras_n_d <= ram_ras_n_i;
		end
	end

	// falling RAS, refresh cycles never reach the controller
	assign ram_req = ras_n_d && !ram_ras_n_i && !ram_ref_i;

	always_comb begin
		sdram_o.din = dl_active_i ? dl_data_i : ram_din_i;
		if (slot_i.cpu_cycle && dl_active_i) begin
			// upload owns the cpu slot
			sdram_o.req  = dl_wr_i;
			sdram_o.we   = 1'b1;
			sdram_o.ds   = 2'b11;
			sdram_o.addr = dl_addr_i;
		end else if (slot_i.viking_cycle && viking_active_i && viking_read_i) begin
			// video fetch reads the full word
			sdram_o.req  = 1'b1;
			sdram_o.we   = 1'b0;
			sdram_o.ds   = 2'b11;
			sdram_o.addr = viking_addr_i;
		end else begin
			sdram_o.req  = ram_req && ram_en_i;
			sdram_o.we   = !ram_we_n_i;
			sdram_o.ds   = {ram_uds_i, ram_lds_i};
			sdram_o.addr = ram_addr_i;
		end
	end

endmodule

`default_nettype wire

/* src/st_bus_pkg.sv */
`default_nettype none

package st_bus_pkg;

	// 68000 word address, no A0
	typedef logic [23:1] word_addr_t;

	typedef logic [15:0] bus_word_t;

	// four 32 MHz slots per 8 MHz bus cycle
	typedef enum logic [1:0] {
		slot0 = 2'd0,
		slot1 = 2'd1,
		slot2 = 2'd2,
		slot3 = 2'd3
	} bus_slot_e;

	typedef struct packed {
		logic cpu_precycle;
		logic cpu_cycle;
		// also the shifter cycle
		logic viking_cycle;
		logic viking_precycle;
	} slot_t;

	// request bundle towards the SDRAM controller
	typedef struct packed {
		logic       req;
		logic       we;
		// upper, lower
		logic [1:0] ds;
		word_addr_t addr;
		bus_word_t  din;
	} sdram_req_t;

endpackage

`default_nettype wire

/* src/st_cfg_pkg.sv */
`default_nettype none

package st_cfg_pkg;

	// RAM size in config encoding order
	typedef enum logic [2:0] {
		mem_512k = 3'd0,
		mem_1m   = 3'd1,
		mem_2m   = 3'd2,
		mem_4m   = 3'd3,
		mem_8m   = 3'd4,
		mem_14m  = 3'd5
	} mem_size_e;

	typedef struct packed {
		mem_size_e mem_size;
		logic      viking_en;
		// STE on steroids, moves the viking window up to e80000
		logic      steroids;
	} st_cfg_t;

	// viking window tags
	// c00000-c3ffff, address bits 23:18
	localparam logic [5:0] VIKING_LO_TAG = 6'b110000;
	// e80000-efffff, address bits 23:19
	localparam logic [4:0] VIKING_HI_TAG = 5'b11101;

endpackage

`default_nettype wire

/* src/st_sdram_mux.sv */
`default_nettype none

module st_sdram_mux #(
	parameter int VIKING_HITS = 255
) (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  st_cfg_pkg::st_cfg_t    cfg_i,
	input  st_bus_pkg::bus_slot_e  bus_cycle_i,
	input  logic                   turbo_i,
	input  logic                   mhz8_en1_i,
	input  logic                   cpu_as_n_i,
	input  st_bus_pkg::word_addr_t cpu_addr_i,
	input  logic                   rom2_n_i,
	input  logic                   ram_ras_n_i,
	input  logic                   ram_ref_i,
	input  logic                   ram_we_n_i,
	input  logic                   ram_uds_i,
	input  logic                   ram_lds_i,
	input  st_bus_pkg::word_addr_t ram_addr_i,
	input  st_bus_pkg::bus_word_t  ram_din_i,
	input  logic                   viking_read_i,
	input  st_bus_pkg::word_addr_t viking_addr_i,
	input  logic                   dl_strobe_i,
	input  logic                   dl_active_i,
	input  st_bus_pkg::word_addr_t dl_addr_i,
	input  st_bus_pkg::bus_word_t  dl_data_i,
	output st_bus_pkg::sdram_req_t sdram_o,
	output st_bus_pkg::word_addr_t rom_addr_o,
	output logic                   viking_active_o,
	output logic                   tos192k_o
);

	st_bus_pkg::slot_t slot;
	logic              ram_en;
	logic              viking_enable;
	logic              cpu_in_window;
	logic              dl_wr;

	mem_map_decode u_decode (
		.cfg_i           (cfg_i),
		.bus_cycle_i     (bus_cycle_i),
		.turbo_i         (turbo_i),
		.ram_addr_i      (ram_addr_i),
		.cpu_addr_i      (cpu_addr_i),
		.slot_o          (slot),
		.ram_en_o        (ram_en),
		.viking_enable_o (viking_enable),
		.cpu_in_window_o (cpu_in_window)
	);

	viking_detect #(
		.VIKING_HITS (VIKING_HITS)
	) u_viking (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.mhz8_en1_i      (mhz8_en1_i),
		.cpu_as_n_i      (cpu_as_n_i),
		.cpu_in_window_i (cpu_in_window),
		.viking_active_o (viking_active_o)
	);

	rom_upload u_upload (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.slot_i      (slot),
		.mhz8_en1_i  (mhz8_en1_i),
		.dl_strobe_i (dl_strobe_i),
		.dl_active_i (dl_active_i),
		.dl_addr_i   (dl_addr_i),
		.cpu_addr_i  (cpu_addr_i),
		.rom2_n_i    (rom2_n_i),
		.dl_wr_o     (dl_wr),
		.tos192k_o   (tos192k_o),
		.rom_addr_o  (rom_addr_o)
	);

	// video fetch only once the card driver is running
	sdram_req_mux u_mux (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.slot_i          (slot),
		.ram_en_i        (ram_en),
		.viking_active_i (viking_active_o && viking_enable),
		.viking_read_i   (viking_read_i),
		.viking_addr_i   (viking_addr_i),
		.dl_active_i     (dl_active_i),
		.dl_wr_i         (dl_wr),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.ram_ras_n_i     (ram_ras_n_i),
		.ram_ref_i       (ram_ref_i),
		.ram_we_n_i      (ram_we_n_i),
		.ram_uds_i       (ram_uds_i),
		.ram_lds_i       (ram_lds_i),
		.ram_addr_i      (ram_addr_i),
		.ram_din_i       (ram_din_i),
		.sdram_o         (sdram_o)
	);

endmodule

`default_nettype wire

/* src/viking_detect.sv */
`default_nettype none

module viking_detect #(
	parameter int VIKING_HITS = 255
) (
	input  logic clk_32,
	input  logic xsint,
	input  logic mhz8_en1_i,
	input  logic cpu_as_n_i,
	input  logic cpu_in_window_i,
	output logic viking_active_o
);

	localparam int CNT_W = $clog2(VIKING_HITS + 1);
	localparam logic [CNT_W-1:0] HITS = CNT_W'(VIKING_HITS);

	logic [CNT_W-1:0] hit_cnt;

	// a driver hammers the window, a stray probe does not
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			hit_cnt         <= '0;
			viking_active_o <= 1'b0;
		end else begin
			if (mhz8_en1_i && !cpu_as_n_i && cpu_in_window_i && hit_cnt != HITS) begin
				hit_cnt <= hit_cnt + 1'b1;
			end
			// saturated count holds this high until reset
			viking_active_o <= (hit_cnt == HITS);
		end
	end

endmodule

`default_nettype wire

/* test/st_sdram_mux_properties.sv */
`default_nettype none

module st_sdram_mux_properties (
	input logic                   clk_32,
	input logic                   xsint,
	input st_bus_pkg::slot_t      slot_i,
	input logic                   dl_wr_i,
	input logic                   dl_active_i,
	input logic                   viking_active_i,
	input logic                   viking_read_i,
	input logic                   ram_ref_i,
	input st_bus_pkg::sdram_req_t sdram_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	logic chip_path;

	// neither upload nor video fetch owns the slot
	assign chip_path = !(slot_i.cpu_cycle && dl_active_i) &&
	                   !(slot_i.viking_cycle && viking_active_i && viking_read_i);

	dl_wr_single: assert property (@(posedge clk_32) disable iff (!xsint)
		dl_wr_i |=> !dl_wr_i)
		else begin
			fail_count++;
			$error("dl_wr stayed high for two cycles");
		end

	// card stays on once the driver was seen
	viking_sticky: assert property (@(posedge clk_32) disable iff (!xsint)
		viking_active_i |=> viking_active_i)
		else begin
			fail_count++;
			$error("viking_active fell without reset");
		end

	no_refresh_req: assert property (@(posedge clk_32) disable iff (!xsint)
		ram_ref_i && chip_path |-> !sdram_i.req)
		else begin
			fail_count++;
			$error("chipset request during refresh");
		end

	upload_both_bytes: assert property (@(posedge clk_32) disable iff (!xsint)
		slot_i.cpu_cycle && dl_active_i && sdram_i.req |-> sdram_i.ds == 2'b11)
		else begin
			fail_count++;
			$error("upload write without both byte strobes");
		end

endmodule

bind st_sdram_mux st_sdram_mux_properties props0 (
	.clk_32          (clk_32),
	.xsint           (xsint),
	.slot_i          (slot),
	.dl_wr_i         (dl_wr),
	.dl_active_i     (dl_active_i),
	.viking_active_i (viking_active_o),
	.viking_read_i   (viking_read_i),
	.ram_ref_i       (ram_ref_i),
	.sdram_i         (sdram_o)
);

`default_nettype wire

/* test/tb_st_sdram_mux.sv */
`default_nettype none

module tb_st_sdram_mux;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	// rough cycle count of reset plus all tests
	localparam int TEST_CYCLES = 140;

	logic                   clk_32;
	logic                   xsint;
	st_cfg_pkg::st_cfg_t    cfg_i;
	st_bus_pkg::bus_slot_e  bus_cycle_i;
	logic                   turbo_i;
	logic                   mhz8_en1_i;
	logic                   cpu_as_n_i;
	st_bus_pkg::word_addr_t cpu_addr_i;
	logic                   rom2_n_i;
	logic                   ram_ras_n_i;
	logic                   ram_ref_i;
	logic                   ram_we_n_i;
	logic                   ram_uds_i;
	logic                   ram_lds_i;
	st_bus_pkg::word_addr_t ram_addr_i;
	st_bus_pkg::bus_word_t  ram_din_i;
	logic                   viking_read_i;
	st_bus_pkg::word_addr_t viking_addr_i;
	logic                   dl_strobe_i;
	logic                   dl_active_i;
	st_bus_pkg::word_addr_t dl_addr_i;
	st_bus_pkg::bus_word_t  dl_data_i;
	st_bus_pkg::sdram_req_t sdram_o;
	st_bus_pkg::word_addr_t rom_addr_o;
	logic                   viking_active_o;
	logic                   tos192k_o;

	int          err_req;
	int          err_addr;
	int          err_bit;
	logic [31:0] lcg_state;

	st_sdram_mux #(
		.VIKING_HITS (16)
	) dut0 (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg_i),
		.bus_cycle_i     (bus_cycle_i),
		.turbo_i         (turbo_i),
		.mhz8_en1_i      (mhz8_en1_i),
		.cpu_as_n_i      (cpu_as_n_i),
		.cpu_addr_i      (cpu_addr_i),
		.rom2_n_i        (rom2_n_i),
		.ram_ras_n_i     (ram_ras_n_i),
		.ram_ref_i       (ram_ref_i),
		.ram_we_n_i      (ram_we_n_i),
		.ram_uds_i       (ram_uds_i),
		.ram_lds_i       (ram_lds_i),
		.ram_addr_i      (ram_addr_i),
		.ram_din_i       (ram_din_i),
		.viking_read_i   (viking_read_i),
		.viking_addr_i   (viking_addr_i),
		.dl_strobe_i     (dl_strobe_i),
		.dl_active_i     (dl_active_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.sdram_o         (sdram_o),
		.rom_addr_o      (rom_addr_o),
		.viking_active_o (viking_active_o),
		.tos192k_o       (tos192k_o)
	);

	always #(CLK_PERIOD / 2) clk_32 = ~clk_32;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// RAM size in words
	function automatic int unsigned size_words(st_cfg_pkg::mem_size_e size);
		int unsigned bytes;
		case (size)
			st_cfg_pkg::mem_512k: bytes = 32'h0008_0000;
			st_cfg_pkg::mem_1m:   bytes = 32'h0010_0000;
			st_cfg_pkg::mem_2m:   bytes = 32'h0020_0000;
			st_cfg_pkg::mem_4m:   bytes = 32'h0040_0000;
			st_cfg_pkg::mem_8m:   bytes = 32'h0080_0000;
			default:              bytes = 32'h00e0_0000;
		endcase
		return bytes / 2;
	endfunction

	// system rom base is fc0000 for 192k TOS and e00000 otherwise
	function automatic st_bus_pkg::word_addr_t rom_expect(st_bus_pkg::word_addr_t a,
		logic tos192k);
		logic [23:0] byte_addr;
		byte_addr = {a, 1'b0} & 24'h03_ffff;
		if (tos192k) begin
			byte_addr = byte_addr | 24'hfc_0000;
		end else begin
			byte_addr = byte_addr | 24'he0_0000;
		end
		return byte_addr[23:1];
	endfunction

	task automatic check_req(input string name, input st_bus_pkg::sdram_req_t got,
		input st_bus_pkg::sdram_req_t exp);
		if (got !== exp) begin
			err_req++;
			$display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input st_bus_pkg::word_addr_t got,
		input st_bus_pkg::word_addr_t exp);
		if (got !== exp) begin
			err_addr++;
			$display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_bit++;
			$display("CHECK FAILED at %0d ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// RAS high for a cycle and then falling with a fresh chipset request
	task automatic ras_cycle(input st_bus_pkg::word_addr_t addr, input logic refresh,
		input logic hit);
		logic [31:0]            r;
		st_bus_pkg::sdram_req_t exp;
		r = next_rand();
		@(negedge clk_32);
		ram_ras_n_i = 1'b1;
		ram_ref_i   = refresh;
		@(negedge clk_32);
		ram_ras_n_i = 1'b0;
		ram_addr_i  = addr;
		ram_we_n_i  = r[0];
		ram_uds_i   = r[1];
		ram_lds_i   = r[2];
		ram_din_i   = r[31:16];
		#2;
		exp.req  = hit && !refresh;
		exp.we   = !r[0];
		exp.ds   = {r[1], r[2]};
		exp.addr = addr;
		exp.din  = r[31:16];
		check_req("sdram_o", sdram_o, exp);
		@(negedge clk_32);
		#2;
		check_bit("sdram_o.req", sdram_o.req, 1'b0);
	endtask

	task automatic cpu_access(input st_bus_pkg::word_addr_t a);
		@(negedge clk_32);
		cpu_addr_i = a;
		cpu_as_n_i = 1'b0;
		mhz8_en1_i = 1'b1;
		@(negedge clk_32);
		cpu_as_n_i = 1'b1;
		mhz8_en1_i = 1'b0;
		#2;
	endtask

	task automatic ram_window_sweep();
		int                     i;
		int unsigned            limit;
		logic [31:0]            r;
		st_bus_pkg::word_addr_t inside_addr;
		st_bus_pkg::word_addr_t outside_addr;
		for (i = 0; i < 6; i++) begin
			@(negedge clk_32);
			cfg_i.mem_size = st_cfg_pkg::mem_size_e'(i);
			limit = size_words(cfg_i.mem_size);
			r = next_rand();
			inside_addr = st_bus_pkg::word_addr_t'(r % limit);
			r = next_rand();
			outside_addr = st_bus_pkg::word_addr_t'(limit + (r % (32'h0080_0000 - limit)));
			ras_cycle(inside_addr, 1'b0, 1'b1);
			ras_cycle(outside_addr, 1'b0, 1'b0);
			ras_cycle(inside_addr, 1'b1, 1'b1);
		end
	endtask

	task automatic viking_activation();
		int          i;
		logic [31:0] r;
		@(negedge clk_32);
		cfg_i.mem_size  = st_cfg_pkg::mem_4m;
		cfg_i.viking_en = 1'b1;
		cfg_i.steroids  = 1'b0;
		ram_ref_i       = 1'b0;
		for (i = 0; i < 15; i++) begin
			r = next_rand();
			cpu_access({6'b110000, r[16:0]});
			// just above c3ffff so it must not count
			if (i % 4 == 0) begin
				cpu_access({6'b110001, r[16:0]});
			end
		end
		check_bit("viking_active_o", viking_active_o, 1'b0);
		r = next_rand();
		cpu_access({6'b110000, r[16:0]});
		check_bit("viking_active_o", viking_active_o, 1'b0);
		@(negedge clk_32);
		#2;
		check_bit("viking_active_o", viking_active_o, 1'b1);
	endtask

	task automatic video_fetch_override();
		logic [31:0]            r;
		st_bus_pkg::word_addr_t vaddr;
		st_bus_pkg::word_addr_t raddr;
		r = next_rand();
		vaddr = r[22:0];
		r = next_rand();
		raddr = {2'b00, r[20:0]};
		@(negedge clk_32);
		ram_ras_n_i   = 1'b1;
		bus_cycle_i   = st_bus_pkg::slot2;
		viking_read_i = 1'b1;
		viking_addr_i = vaddr;
		ram_addr_i    = raddr;
		@(negedge clk_32);
		// chipset RAS falls in the video slot
		ram_ras_n_i = 1'b0;
		#2;
		check_bit("sdram_o.req", sdram_o.req, 1'b1);
		check_bit("sdram_o.we", sdram_o.we, 1'b0);
		check_addr("sdram_o.addr", sdram_o.addr, vaddr);
		@(negedge clk_32);
		turbo_i     = 1'b1;
		bus_cycle_i = st_bus_pkg::slot3;
		#2;
		check_bit("sdram_o.req", sdram_o.req, 1'b1);
		check_addr("sdram_o.addr", sdram_o.addr, vaddr);
		@(negedge clk_32);
		turbo_i       = 1'b0;
		bus_cycle_i   = st_bus_pkg::slot2;
		viking_read_i = 1'b0;
		ram_ras_n_i   = 1'b1;
		@(negedge clk_32);
		ram_ras_n_i = 1'b0;
		#2;
		check_bit("sdram_o.req", sdram_o.req, 1'b1);
		check_addr("sdram_o.addr", sdram_o.addr, raddr);
	endtask

	task automatic upload_write();
		int                     i;
		logic [31:0]            r;
		st_bus_pkg::sdram_req_t exp;
		r = next_rand();
		@(negedge clk_32);
		bus_cycle_i = st_bus_pkg::slot0;
		mhz8_en1_i  = 1'b1;
		dl_active_i = 1'b1;
		dl_addr_i   = r[22:0];
		dl_data_i   = r[31:16];
		dl_strobe_i = !dl_strobe_i;
		exp.req  = 1'b1;
		exp.we   = 1'b1;
		exp.ds   = 2'b11;
		exp.addr = r[22:0];
		exp.din  = r[31:16];
		@(negedge clk_32);
		bus_cycle_i = st_bus_pkg::slot1;
		mhz8_en1_i  = 1'b0;
		#2;
		check_req("sdram_o", sdram_o, exp);
		// one more bus cycle without a toggle
		for (i = 0; i < 5; i++) begin
			@(negedge clk_32);
			bus_cycle_i = st_bus_pkg::bus_slot_e'((i + 2) % 4);
			mhz8_en1_i  = (bus_cycle_i == st_bus_pkg::slot0);
			#2;
			check_bit("sdram_o.req", sdram_o.req, 1'b0);
		end
	endtask

	task automatic rom_remap();
		logic [31:0]            r;
		st_bus_pkg::word_addr_t a;
		r = next_rand();
		@(negedge clk_32);
		mhz8_en1_i  = 1'b0;
		dl_active_i = 1'b1;
		dl_addr_i   = {6'b111111, r[16:0]};
		r = next_rand();
		a = r[22:0];
		@(negedge clk_32);
		dl_active_i = 1'b0;
		rom2_n_i    = 1'b0;
		cpu_addr_i  = a;
		#2;
		check_bit("tos192k_o", tos192k_o, 1'b1);
		check_addr("rom_addr_o", rom_addr_o, rom_expect(a, 1'b1));
		r = next_rand();
		@(negedge clk_32);
		dl_active_i = 1'b1;
		dl_addr_i   = {4'he, r[18:0]};
		rom2_n_i    = 1'b1;
		r = next_rand();
		a = r[22:0];
		@(negedge clk_32);
		dl_active_i = 1'b0;
		rom2_n_i    = 1'b0;
		cpu_addr_i  = a;
		#2;
		check_bit("tos192k_o", tos192k_o, 1'b0);
		check_addr("rom_addr_o", rom_addr_o, rom_expect(a, 1'b0));
		r = next_rand();
		a = r[22:0];
		@(negedge clk_32);
		rom2_n_i   = 1'b1;
		cpu_addr_i = a;
		#2;
		check_addr("rom_addr_o", rom_addr_o, a);
	endtask

	initial begin
		clk_32             = 1'b0;
		xsint              = 1'b0;
		cfg_i.mem_size     = st_cfg_pkg::mem_512k;
		cfg_i.viking_en    = 1'b0;
		cfg_i.steroids     = 1'b0;
		bus_cycle_i        = st_bus_pkg::slot0;
		turbo_i            = 1'b0;
		mhz8_en1_i         = 1'b0;
		cpu_as_n_i         = 1'b1;
		cpu_addr_i         = '0;
		rom2_n_i           = 1'b1;
		ram_ras_n_i        = 1'b1;
		ram_ref_i          = 1'b0;
		ram_we_n_i         = 1'b1;
		ram_uds_i          = 1'b0;
		ram_lds_i          = 1'b0;
		ram_addr_i         = '0;
		ram_din_i          = '0;
		viking_read_i      = 1'b0;
		viking_addr_i      = '0;
		dl_strobe_i        = 1'b0;
		dl_active_i        = 1'b0;
		dl_addr_i          = '0;
		dl_data_i          = '0;
		err_req            = 0;
		err_addr           = 0;
		err_bit            = 0;
		lcg_state          = 32'd30;
		repeat (8) @(negedge clk_32);
		xsint = 1'b1;
		ram_window_sweep();
		viking_activation();
		video_fetch_override();
		upload_write();
		rom_remap();
		@(negedge clk_32);
		$display("errors: req %0d, addr %0d, flag %0d, assertion %0d",
			err_req, err_addr, err_bit, dut0.props0.fail_count);
		if (err_req + err_addr + err_bit + dut0.props0.fail_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
